/* project.f */
+incdir+verif
rtl/hive_pkg.sv
rtl/acc_spill_reg.sv
rtl/acc_interconnect.sv
rtl/shared_muldiv.sv
rtl/snitch_hive_acc.sv
verif/tb_hive_acc.sv

/* rtl/acc_interconnect.sv */
/*
  Accelerator interconnect of the hive: round-robin request arbiter
  that extends the id with the core index, and the response demux
  that routes by that index and strips it again
*/
`default_nettype none

module acc_interconnect import hive_pkg::*; (
  input  logic                           clk_i,
  input  logic                           reset_i,
  // Core side
  input  core_acc_req_t [CoreCount-1:0]  core_req_i,
  input  logic          [CoreCount-1:0]  core_qvalid_i,
  output logic          [CoreCount-1:0]  core_qready_o,
  output core_acc_rsp_t [CoreCount-1:0]  core_rsp_o,
  output logic          [CoreCount-1:0]  core_pvalid_o,
  input  logic          [CoreCount-1:0]  core_pready_i,
  // Unit side
  output acc_req_t                       unit_req_o,
  output logic                           unit_qvalid_o,
  input  logic                           unit_qready_i,
  input  acc_rsp_t                       unit_rsp_i,
  input  logic                           unit_pvalid_i,
  output logic                           unit_pready_o
);

  logic [CoreIdWidth-1:0] rr_q;
  logic [CoreIdWidth-1:0] gnt_idx;
  logic [CoreIdWidth-1:0] search_idx;
  logic                   gnt_found;
  logic                   lock_q;
  logic [CoreIdWidth-1:0] lock_idx_q;
  logic                   req_xfer;
  logic [CoreIdWidth-1:0] rsp_sel;

  // --------------------------------------------------
  // Request arbitration
  // --------------------------------------------------
  // First valid core at or after the pointer wins
  always_comb begin
    gnt_idx    = rr_q;
    gnt_found  = 1'b0;
    search_idx = rr_q;
    for (int k = 0; k < CoreCount; k++) begin
      search_idx = rr_q + CoreIdWidth'(k);
      if (!gnt_found && core_qvalid_i[search_idx]) begin
        gnt_idx   = search_idx;
        gnt_found = 1'b1;
      end
    end
    // A stalled grant stays put so the offered request holds still
    if (lock_q) begin
      gnt_idx = lock_idx_q;
    end
  end

  assign unit_qvalid_o = |core_qvalid_i;
  assign req_xfer      = unit_qvalid_o & unit_qready_i;

  always_comb begin
    core_qready_o          = '0;
    core_qready_o[gnt_idx] = unit_qready_i;
  end

  // Core index goes in front of the core's own id
  always_comb begin
    unit_req_o.addr      = core_req_i[gnt_idx].addr;
    unit_req_o.id        = {gnt_idx, core_req_i[gnt_idx].id};
    unit_req_o.data_op   = core_req_i[gnt_idx].data_op;
    unit_req_o.data_arga = core_req_i[gnt_idx].data_arga;
    unit_req_o.data_argb = core_req_i[gnt_idx].data_argb;
    unit_req_o.data_argc = core_req_i[gnt_idx].data_argc;
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rr_q   <= '0;
      lock_q <= 1'b0;
    end else begin
      lock_q <= unit_qvalid_o & ~unit_qready_i;
      if (req_xfer) begin
        rr_q <= gnt_idx + 1'b1;
      end
    end
  end

  // Index of the stalled grant, only read while locked
  always_ff @(posedge clk_i) begin
    lock_idx_q <= gnt_idx;
  end

  // --------------------------------------------------
  // Response routing
  // --------------------------------------------------
  assign rsp_sel       = unit_rsp_i.id[ExtIdWidth-1:IdWidth];
  assign unit_pready_o = core_pready_i[rsp_sel];

  for (genvar i = 0; i < CoreCount; i++) begin : gen_rsp
    assign core_pvalid_o[i]    = unit_pvalid_i & (rsp_sel == CoreIdWidth'(i));
    assign core_rsp_o[i].id    = unit_rsp_i.id[IdWidth-1:0];
    assign core_rsp_o[i].error = unit_rsp_i.error;
    assign core_rsp_o[i].data  = unit_rsp_i.data;
  end

endmodule

`default_nettype wire

/* rtl/acc_spill_reg.sv */
/*
  Two-entry spill register for accelerator requests; both the
  forward path and the ready path leave from flops
*/
`default_nettype none

module acc_spill_reg import hive_pkg::*; (
  input  logic     clk_i,
  input  logic     reset_i,
  input  logic     valid_i,
  output logic     ready_o,
  input  acc_req_t data_i,
  output logic     valid_o,
  input  logic     ready_i,
  output acc_req_t data_o
);

  acc_req_t a_data_q, b_data_q;
  logic     a_full_q, b_full_q;
  logic     a_fill, a_drain;
  logic     b_fill, b_drain;

  // Entry a takes new requests, entry b keeps the older one on a stall
  assign a_fill  = valid_i & ready_o;
  assign a_drain = a_full_q & ~b_full_q;
  assign b_fill  = a_drain & ~ready_i;
  assign b_drain = b_full_q & ready_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      a_full_q <= 1'b0;
      b_full_q <= 1'b0;
    end else begin
      if (a_fill) begin
        a_full_q <= 1'b1;
      end else if (a_drain) begin
        a_full_q <= 1'b0;
      end
      if (b_fill) begin
        b_full_q <= 1'b1;
      end else if (b_drain) begin
        b_full_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (a_fill) a_data_q <= data_i;
    if (b_fill) b_data_q <= a_data_q;
  end

  // Older entry goes out first
  assign valid_o = a_full_q | b_full_q;
  assign data_o  = b_full_q ? b_data_q : a_data_q;
  assign ready_o = ~a_full_q | ~b_full_q;

endmodule

`default_nettype wire

/* rtl/hive_pkg.sv */
/*
  Shared definitions of the hive accelerator path: sizes, the
  M-extension operation encodings and the request/response structs
  seen at the core ports and inside the subsystem
*/
`default_nettype none

package hive_pkg;

  // --------------------------------------------------
  // Sizes
  // --------------------------------------------------
  localparam int unsigned CoreCount   = 4;
  localparam int unsigned DataWidth   = 32;
  localparam int unsigned IdWidth     = 5;
  localparam int unsigned CoreIdWidth = 2;
  localparam int unsigned ExtIdWidth  = IdWidth + CoreIdWidth;

  // Accelerator address of the shared multiply/divide unit
  localparam logic [31:0] AccAddrMuldiv = 32'd0;

  // R-type fields that mark an M-extension instruction
  localparam logic [6:0] OpcodeOp     = 7'b0110011;
  localparam logic [6:0] Funct7Muldiv = 7'b0000001;

  // --------------------------------------------------
  // Operations, encoded as funct3
  // --------------------------------------------------
  typedef enum logic [2:0] {
    MUL    = 3'b000,
    MULH   = 3'b001,
    MULHSU = 3'b010,
    MULHU  = 3'b011,
    DIV    = 3'b100,
    DIVU   = 3'b101,
    REM    = 3'b110,
    REMU   = 3'b111
  } muldiv_op_e;

  // --------------------------------------------------
  // Request and response payloads
  // --------------------------------------------------
  // Core side, plain transaction id
  typedef struct packed {
    logic [31:0]          addr;
    logic [IdWidth-1:0]   id;
    logic [31:0]          data_op;
    logic [DataWidth-1:0] data_arga;
    logic [DataWidth-1:0] data_argb;
    logic [DataWidth-1:0] data_argc;
  } core_acc_req_t;

  // Unit side, core index in the upper id bits
  typedef struct packed {
    logic [31:0]           addr;
    logic [ExtIdWidth-1:0] id;
    logic [31:0]           data_op;
    logic [DataWidth-1:0]  data_arga;
    logic [DataWidth-1:0]  data_argb;
    logic [DataWidth-1:0]  data_argc;
  } acc_req_t;

  typedef struct packed {
    logic [IdWidth-1:0]   id;
    logic                 error;
    logic [DataWidth-1:0] data;
  } core_acc_rsp_t;

  typedef struct packed {
    logic [ExtIdWidth-1:0] id;
    logic                  error;
    logic [DataWidth-1:0]  data;
  } acc_rsp_t;

endpackage

`default_nettype wire

/* rtl/shared_muldiv.sv */
/*
  Shared multiply/divide unit: request decode, two-stage multiplier,
  32-step restoring divider with RISC-V corner cases, response register
*/
`default_nettype none

module shared_muldiv import hive_pkg::*; (
  input  logic     clk_i,
  input  logic     reset_i,
  input  acc_req_t req_i,
  input  logic     qvalid_i,
  output logic     qready_o,
  output acc_rsp_t rsp_o,
  output logic     pvalid_o,
  input  logic     pready_i
);

  typedef enum logic [2:0] {StIdle, StMul, StDiv, StFix, StResp} state_e;

  state_e                   state_q;
  logic [4:0]               cnt_q;
  muldiv_op_e               op, op_q;
  logic                     req_error, accept;
  logic                     sign_a, sign_b, a_neg, b_neg;
  logic [DataWidth-1:0]     a_mag, b_mag;
  logic [DataWidth:0]       mul_a_q, mul_b_q;
  logic [2*DataWidth+1:0]   product;
  logic [DataWidth-1:0]     dividend_q, divisor_q, quo_q, rem_q;
  logic                     neg_quo_q, neg_rem_q, div_zero_q;
  logic [DataWidth:0]       rem_shift, rem_diff;
  logic                     rem_ge;
  logic [DataWidth-1:0]     quo_fix, rem_fix, div_result;
  acc_rsp_t                 rsp_q;

  // --------------------------------------------------
  // Decode
  // --------------------------------------------------
  assign op        = muldiv_op_e'(req_i.data_op[14:12]);
  assign req_error = (req_i.addr != AccAddrMuldiv)
                   | (req_i.data_op[6:0] != OpcodeOp)
                   | (req_i.data_op[31:25] != Funct7Muldiv);
  assign accept    = qvalid_i & qready_o;

  // Operand signedness for multiply and divide
  assign sign_a = (op == MULH) | (op == MULHSU);
  assign sign_b = (op == MULH);
  assign a_neg  = ((op == DIV) | (op == REM)) & req_i.data_arga[DataWidth-1];
  assign b_neg  = ((op == DIV) | (op == REM)) & req_i.data_argb[DataWidth-1];
  assign a_mag  = a_neg ? -req_i.data_arga : req_i.data_arga;
  assign b_mag  = b_neg ? -req_i.data_argb : req_i.data_argb;

  // --------------------------------------------------
  // Sequencing
  // --------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= StIdle;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        StIdle: begin
          cnt_q <= '0;
          if (accept) begin
            if (req_error)    state_q <= StResp;
            else if (op[2])   state_q <= StDiv;
            else              state_q <= StMul;
          end
        end
        StMul: state_q <= StResp;
        StDiv: begin
          cnt_q <= cnt_q + 1'b1;
          if (cnt_q == 5'd31) begin
            state_q <= StFix;
          end
        end
        StFix: state_q <= StResp;
        StResp: begin
          if (pready_i) begin
            state_q <= StIdle;
          end
        end
        default: state_q <= StIdle;
      endcase
    end
  end

  assign qready_o = (state_q == StIdle);
  assign pvalid_o = (state_q == StResp);
  assign rsp_o    = rsp_q;

  // --------------------------------------------------
  // Datapath
  // --------------------------------------------------
  assign product = $signed(mul_a_q) * $signed(mul_b_q);

  // One restoring step: shift in next dividend bit, subtract if it fits
  assign rem_shift = {rem_q, quo_q[DataWidth-1]};
  assign rem_ge    = (rem_shift >= {1'b0, divisor_q});
  assign rem_diff  = rem_shift - {1'b0, divisor_q};

  assign quo_fix = neg_quo_q ? -quo_q : quo_q;
  assign rem_fix = neg_rem_q ? -rem_q : rem_q;

  // Divide by zero: quotient all ones, remainder is the dividend
  always_comb begin
    if (div_zero_q) begin
      div_result = op_q[1] ? dividend_q : '1;
    end else begin
      div_result = op_q[1] ? rem_fix : quo_fix;
    end
  end

  always_ff @(posedge clk_i) begin
    case (state_q)
      StIdle: begin
        if (accept) begin
          op_q       <= op;
          mul_a_q    <= {sign_a & req_i.data_arga[DataWidth-1], req_i.data_arga};
          mul_b_q    <= {sign_b & req_i.data_argb[DataWidth-1], req_i.data_argb};
          dividend_q <= req_i.data_arga;
          divisor_q  <= b_mag;
          quo_q      <= a_mag;
          rem_q      <= '0;
          neg_quo_q  <= a_neg ^ b_neg;
          neg_rem_q  <= a_neg;
          div_zero_q <= (req_i.data_argb == '0);
          rsp_q      <= '{id: req_i.id, error: req_error, data: '0};
        end
      end
      StMul: begin
        rsp_q.data <= (op_q == MUL) ? product[DataWidth-1:0]
                                    : product[2*DataWidth-1:DataWidth];
      end
      StDiv: begin
        quo_q <= {quo_q[DataWidth-2:0], rem_ge};
        rem_q <= rem_ge ? rem_diff[DataWidth-1:0] : rem_shift[DataWidth-1:0];
      end
      StFix: rsp_q.data <= div_result;
      default: ;
    endcase
  end

endmodule

`default_nettype wire

/* rtl/snitch_hive_acc.sv */
/*
  Shared accelerator path of the hive: interconnect, spill register
  and the shared multiply/divide unit
*/
`default_nettype none

module snitch_hive_acc import hive_pkg::*; (
  input  logic                          clk_i,
  input  logic                          reset_i,
  input  core_acc_req_t [CoreCount-1:0] acc_req_i,
  input  logic          [CoreCount-1:0] acc_qvalid_i,
  output logic          [CoreCount-1:0] acc_qready_o,
  output core_acc_rsp_t [CoreCount-1:0] acc_rsp_o,
  output logic          [CoreCount-1:0] acc_pvalid_o,
  input  logic          [CoreCount-1:0] acc_pready_i
);

  // Arbiter to spill register
  acc_req_t arb_req;
  logic     arb_qvalid, arb_qready;
  // Spill register to unit
  acc_req_t unit_req;
  logic     unit_qvalid, unit_qready;
  // Unit responses
  acc_rsp_t unit_rsp;
  logic     unit_pvalid, unit_pready;

  acc_interconnect u_acc_interconnect (
    .clk_i         ( clk_i        ),
    .reset_i       ( reset_i      ),
    .core_req_i    ( acc_req_i    ),
    .core_qvalid_i ( acc_qvalid_i ),
    .core_qready_o ( acc_qready_o ),
    .core_rsp_o    ( acc_rsp_o    ),
    .core_pvalid_o ( acc_pvalid_o ),
    .core_pready_i ( acc_pready_i ),
    .unit_req_o    ( arb_req      ),
    .unit_qvalid_o ( arb_qvalid   ),
    .unit_qready_i ( arb_qready   ),
    .unit_rsp_i    ( unit_rsp     ),
    .unit_pvalid_i ( unit_pvalid  ),
    .unit_pready_o ( unit_pready  )
  );

  acc_spill_reg u_acc_spill_reg (
    .clk_i   ( clk_i       ),
    .reset_i ( reset_i     ),
    .valid_i ( arb_qvalid  ),
    .ready_o ( arb_qready  ),
    .data_i  ( arb_req     ),
    .valid_o ( unit_qvalid ),
    .ready_i ( unit_qready ),
    .data_o  ( unit_req    )
  );

  shared_muldiv u_shared_muldiv (
    .clk_i    ( clk_i       ),
    .reset_i  ( reset_i     ),
    .req_i    ( unit_req    ),
    .qvalid_i ( unit_qvalid ),
    .qready_o ( unit_qready ),
    .rsp_o    ( unit_rsp    ),
    .pvalid_o ( unit_pvalid ),
    .pready_i ( unit_pready )
  );

endmodule

`default_nettype wire

/* verif/hive_acc_model.svh */
/*
  Reference model of the shared unit: M-extension results by the
  RISC-V rules, the request error rule and the expected core response
*/

// Result of one M operation, with the RISC-V divide corner cases
function automatic logic [31:0] muldiv_result(input muldiv_op_e op,
                                               input logic [31:0] a,
                                               input logic [31:0] b);
  logic [63:0] a_ext;
  logic [63:0] b_ext;
  logic [63:0] prod;
  logic        overflow;
  a_ext    = (op == MULH || op == MULHSU) ? {{32{a[31]}}, a} : {32'd0, a};
  b_ext    = (op == MULH) ? {{32{b[31]}}, b} : {32'd0, b};
  // Once both operands are extended, the low 64 product bits are exact
  prod     = a_ext * b_ext;
  overflow = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
  case (op)
    MUL:                 return prod[31:0];
    MULH, MULHSU, MULHU: return prod[63:32];
    DIV: begin
      if (b == '0) return '1;
      else if (overflow) return a;
      else return $signed(a) / $signed(b);
    end
    DIVU: return (b == '0) ? '1 : a / b;
    REM: begin
      if (b == '0) return a;
      else if (overflow) return '0;
      else return $signed(a) % $signed(b);
    end
    REMU:    return (b == '0) ? a : a % b;
    default: return '0;
  endcase
endfunction

// Address or encoding that the unit does not serve
function automatic logic bad_request(input core_acc_req_t r);
  return (r.addr != AccAddrMuldiv) || (r.data_op[6:0] != OpcodeOp)
      || (r.data_op[31:25] != Funct7Muldiv);
endfunction

// Response the issuing core should see for a request
function automatic core_acc_rsp_t expected_rsp(input core_acc_req_t r);
  core_acc_rsp_t rsp;
  rsp.id    = r.id;
  rsp.error = bad_request(r);
  rsp.data  = rsp.error ? '0 : muldiv_result(muldiv_op_e'(r.data_op[14:12]),
                                             r.data_arga, r.data_argb);
  return rsp;
endfunction

/* verif/tb_hive_acc.sv */
/*
  Testbench of the hive accelerator path: clock, reset, random requests
  from four cores, per-core expected responses and the checks on them
*/
`default_nettype none

module tb_hive_acc
  import hive_pkg::*;
();

  localparam int Seed            = 26;
  localparam int DirectedPerCore = 2;
  localparam int FairPerCore     = 6;
  localparam int RandomPerCore   = 40;
  localparam int StallPerCore    = 4;
  localparam int StallCycles     = 60;
  // Each request may take up to 40 cycles when it is a divide
  localparam int TimeoutCycles   = CoreCount * 40 * (DirectedPerCore + FairPerCore
                                   + RandomPerCore + StallPerCore) + StallCycles + 500;

  logic                          clk_i = 1'b0;
  logic                          reset_i;
  core_acc_req_t [CoreCount-1:0] acc_req_i;
  logic          [CoreCount-1:0] acc_qvalid_i, acc_qready_o;
  core_acc_rsp_t [CoreCount-1:0] acc_rsp_o;
  logic          [CoreCount-1:0] acc_pvalid_o, acc_pready_i;

  // Expected responses per core in arrival order
  core_acc_rsp_t        exp_q [CoreCount][$];
  core_acc_req_t        directed_q [$];
  logic [IdWidth-1:0]   next_id [CoreCount] = '{default: '0};
  int                   remaining [CoreCount] = '{default: 0};
  logic [CoreCount-1:0] taken = '0;
  int                   valid_pct = 0, stall_pct = 0, last_core = 0;
  bit                   pready_hold = 1'b0, check_rotation = 1'b0, have_last = 1'b0;
  int                   err_count = 0, rsp_count = 0, test_count = 0, cycle_count = 0;

  `include "hive_acc_model.svh"

  snitch_hive_acc u_snitch_hive_acc (
    .clk_i        ( clk_i        ),
    .reset_i      ( reset_i      ),
    .acc_req_i    ( acc_req_i    ),
    .acc_qvalid_i ( acc_qvalid_i ),
    .acc_qready_o ( acc_qready_o ),
    .acc_rsp_o    ( acc_rsp_o    ),
    .acc_pvalid_o ( acc_pvalid_o ),
    .acc_pready_i ( acc_pready_i )
  );

  always #4 clk_i = ~clk_i;

  // M request with random register fields and a random third operand
  function automatic core_acc_req_t build_req(input logic [2:0] funct3,
                                              input logic [31:0] a, input logic [31:0] b);
    core_acc_req_t r;
    r.addr      = AccAddrMuldiv;
    r.id        = '0;
    r.data_op   = {Funct7Muldiv, 5'($urandom), 5'($urandom), funct3, 5'($urandom), OpcodeOp};
    r.data_arga = a;
    r.data_argb = b;
    r.data_argc = $urandom;
    return r;
  endfunction

  // Directed cases go first and about one random request in eight is malformed
  function automatic core_acc_req_t next_request(input int c);
    core_acc_req_t r;
    int unsigned   pick;
    if (directed_q.size() > 0) begin
      r = directed_q.pop_front();
    end else begin
      pick = $urandom_range(23);
      r = build_req(3'($urandom), $urandom,
                    ($urandom_range(3) == 0) ? 32'($urandom_range(15)) : $urandom);
      if (pick == 0) r.data_op[31:25] = Funct7Muldiv ^ 7'($urandom_range(127, 1));
      if (pick == 1) r.addr = 32'($urandom_range(255, 1));
      if (pick == 2) r.data_op[6:0] = OpcodeOp ^ 7'($urandom_range(127, 1));
    end
    r.id       = next_id[c];
    next_id[c] = next_id[c] + 1'b1;
    return r;
  endfunction

  function automatic int outstanding();
    int n;
    n = 0;
    for (int c = 0; c < CoreCount; c++) n += exp_q[c].size();
    return n;
  endfunction

  task automatic run_test(input string name, input int per_core, input int vpct,
                          input int spct, input int hold, input bit rotate);
    int err_start;
    int rsp_start;
    err_start      = err_count;
    rsp_start      = rsp_count;
    valid_pct      = vpct;
    stall_pct      = spct;
    check_rotation = rotate;
    have_last      = 1'b0;
    for (int c = 0; c < CoreCount; c++) remaining[c] = per_core;
    if (hold > 0) begin
      pready_hold = 1'b1;
      repeat (hold) @(posedge clk_i);
      @(negedge clk_i);
      // One request waits in the unit and two in the spill register
      assert (outstanding() == 3 && acc_qready_o == '0) else begin
        $display("Stalled responses did not block all cores with three requests in flight");
        err_count++;
      end
      pready_hold = 1'b0;
    end
    do begin
      @(posedge clk_i);
    end while (remaining.sum() > 0 || acc_qvalid_i != '0 || outstanding() > 0);
    test_count++;
    $display("Test %0s done: %0d responses, %0d errors", name,
             rsp_count - rsp_start, err_count - err_start);
  endtask

  // --------------------------------------------------
  // Core drivers one step after each rising edge
  // --------------------------------------------------
  initial begin : drive_inputs
    int unsigned seed_init;
    seed_init = $urandom(Seed);
    directed_q.push_back(build_req(DIV, 32'h1234_5678, 32'd0));
    directed_q.push_back(build_req(DIVU, 32'h8765_4321, 32'd0));
    directed_q.push_back(build_req(REM, 32'hdead_beef, 32'd0));
    directed_q.push_back(build_req(REMU, 32'h0000_0007, 32'd0));
    directed_q.push_back(build_req(DIV, 32'h8000_0000, 32'hffff_ffff));
    directed_q.push_back(build_req(REM, 32'h8000_0000, 32'hffff_ffff));
    directed_q.push_back(build_req(MULH, 32'h8000_0000, 32'h8000_0000));
    directed_q.push_back(build_req(MULHSU, 32'hffff_ffff, 32'hffff_ffff));
    forever begin
      @(posedge clk_i);
      #1;
      for (int c = 0; c < CoreCount; c++) begin
        if (taken[c]) acc_qvalid_i[c] = 1'b0;
        if (!acc_qvalid_i[c] && remaining[c] > 0 && $urandom_range(99) < valid_pct) begin
          acc_req_i[c]    = next_request(c);
          acc_qvalid_i[c] = 1'b1;
          remaining[c]--;
        end
        acc_pready_i[c] = !pready_hold && ($urandom_range(99) >= stall_pct);
      end
    end
  end

  // Transfers and responses seen at mid-cycle on the falling edge
  always @(negedge clk_i) begin : check_outputs
    core_acc_rsp_t exp_rsp;
    for (int c = 0; c < CoreCount; c++) begin
      taken[c] = !reset_i && acc_qvalid_i[c] && acc_qready_o[c];
      if (taken[c]) begin
        exp_q[c].push_back(expected_rsp(acc_req_i[c]));
        if (check_rotation && have_last) begin
          assert (c == (last_core + 1) % CoreCount) else begin
            $display("Arbiter granted core %0d right after core %0d, out of turn",
                     c, last_core);
            err_count++;
          end
        end
        last_core = c;
        have_last = 1'b1;
      end
      if (!reset_i && acc_pvalid_o[c] && acc_pready_i[c]) begin
        rsp_count++;
        assert (exp_q[c].size() > 0) else begin
          $display("Core %0d got a response with no request outstanding", c);
          err_count++;
        end
        if (exp_q[c].size() > 0) begin
          exp_rsp = exp_q[c].pop_front();
          assert (acc_rsp_o[c] == exp_rsp) else begin
            $display("Fail acc_rsp_o[%0d] {id,error,data} expected %h actual %h",
                     c, exp_rsp, acc_rsp_o[c]);
            err_count++;
          end
        end
      end
    end
  end

  initial begin : watchdog
    while (cycle_count < TimeoutCycles) begin
      @(posedge clk_i);
      cycle_count++;
    end
    $display("Run timed out after %0d cycles with %0d responses outstanding",
             cycle_count, outstanding());
    $display("CHECKS FAILED");
    $finish;
  end

  initial begin : run_tests
    reset_i      = 1'b1;
    acc_req_i    = '0;
    acc_qvalid_i = '0;
    acc_pready_i = '0;
    repeat (4) @(posedge clk_i);
    #1 reset_i = 1'b0;
    @(posedge clk_i);
    run_test("directed", DirectedPerCore, 100, 0, 0, 1'b0);
    run_test("fairness", FairPerCore, 100, 0, 0, 1'b1);
    run_test("random", RandomPerCore, 60, 30, 0, 1'b0);
    run_test("backpressure", StallPerCore, 100, 30, StallCycles, 1'b0);
    $display("%0d tests, %0d responses checked, %0d errors",
             test_count, rsp_count, err_count);
    if (err_count == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
